// ==== bench/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Executes one instruction on mReg, mMem and mPc and returns the expected register write
function automatic void stepModel(input logic [31:0] ins, output logic en,
	output logic [4:0] wa, output logic [31:0] wd, output logic [31:0] npc);
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] pc4;
	logic [31:0] ea;
	op = ins[31:26];
	fn = ins[5:0];
	rs = ins[25:21];
	rt = ins[20:16];
	a = (rs == 0) ? 32'd0 : mReg[rs];
	b = (rt == 0) ? 32'd0 : mReg[rt];
	sext = {{16{ins[15]}}, ins[15:0]};
	zext = {16'd0, ins[15:0]};
	pc4 = mPc + 32'd4;
	ea = a + sext;
	npc = pc4;
	en = 1'b0;
	wa = rt; // I-type destination
	wd = 32'd0;
	case (op)
		6'd0: begin
			wa = ins[15:11];
			en = 1'b1;
			case (fn)
				6'd32, 6'd33: wd = a + b;
				6'd34, 6'd35: wd = a - b;
				6'd36: wd = a & b;
				6'd37: wd = a | b;
				6'd38: wd = a ^ b;
				6'd39: wd = ~(a | b);
				6'd42: wd = {31'd0, $signed(a) < $signed(b)};
				6'd43: wd = {31'd0, a < b};
				6'd0: begin
					wd = b << ins[10:6];
					en = (rs == 0); // Other rs values are not SLL
				end
				6'd2: begin
					wd = b >> ins[10:6];
					en = (rs == 0);
				end
				6'd8: begin
					en = 1'b0;
					npc = a;
				end
				default: en = 1'b0;
			endcase
		end
		6'd8, 6'd9: {en, wd} = {1'b1, a + sext};
		6'd10: {en, wd} = {1'b1, 31'd0, $signed(a) < $signed(sext)};
		6'd12: {en, wd} = {1'b1, a & zext};
		6'd13: {en, wd} = {1'b1, a | zext};
		6'd14: {en, wd} = {1'b1, a ^ zext};
		6'd15: {en, wd} = {1'b1, ins[15:0], 16'd0};
		6'd35: {en, wd} = {1'b1, mMem[(ea >> 2) % DmemWords]};
		6'd43: mMem[(ea >> 2) % DmemWords] = b;
		6'd4: if (a == b) npc = pc4 + (sext << 2);
		6'd5: if (a != b) npc = pc4 + (sext << 2);
		6'd2: npc = {pc4[31:28], ins[25:0], 2'b00};
		6'd3: begin
			npc = {pc4[31:28], ins[25:0], 2'b00};
			en = 1'b1;
			wa = 5'd31;
			wd = pc4;
		end
		default: en = 1'b0;
	endcase
	if (en && wa != 0) begin
		mReg[wa] = wd;
	end
	mPc = npc;
endfunction

`endif

// ==== bench/tbMipsCore.sv ====
`timescale 1ns/10ps

module tbMipsCore;

	localparam int DmemWords = 256;
	localparam int RunCycles = 400;

	logic clk;
	logic rstN;
	logic [31:0] instr;
	logic [31:0] instrAddr;
	logic wbEn;
	logic [4:0] wbAddr;
	logic [31:0] wbData;

	logic [31:0] prog [64];
	logic [31:0] mReg [32];
	logic [31:0] mMem [DmemWords];
	logic [31:0] mPc;
	integer seed = 32'h04373e23;
	integer resetCycles = 0;

	`include "isaModel.svh"

	mipsCore #(
		.DmemWords(DmemWords)
	) u_mipsCore (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.instrAddr(instrAddr),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
		input int sh, input int fn);
		rType = {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
	endfunction

	function automatic logic [31:0] iType(input int op, input int rs, input int rt,
		input int imm);
		iType = {6'(op), 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	task automatic buildProgram();
		int aluFn [10] = '{32, 33, 34, 35, 36, 37, 38, 39, 42, 43};
		int immOp [6] = '{8, 9, 10, 12, 13, 14};
		int pos;
		int kind;
		int memOfs;
		pos = 0;
		for (int r = 1; r < 8; r++) begin
			prog[pos] = iType(15, 0, r, $random(seed));
			prog[pos+1] = iType(13, r, r, $random(seed));
			pos += 2;
		end
		prog[pos] = iType(13, 0, 31, 4 * 40); // JR lands inside the program
		pos++;
		for (int w = 0; w < 4; w++) begin
			prog[pos] = iType(43, 0, w + 1, w * 4);
			pos++;
		end
		for (int i = pos; i < 64; i++) begin
			kind = $unsigned($random(seed)) % 12;
			memOfs = ($unsigned($random(seed)) % 8) * DmemWords * 4 // Wraps to same word
				+ ($unsigned($random(seed)) % 4) * 4 + ($unsigned($random(seed)) % 4);
			case (kind)
				0, 1, 2: prog[i] = rType($random(seed) & 7, $random(seed) & 7,
					$random(seed) & 7, 0, aluFn[$unsigned($random(seed)) % 10]);
				3: prog[i] = rType(0, $random(seed) & 7, $random(seed) & 7,
					$random(seed) & 31, ($random(seed) & 1) * 2);
				4: prog[i] = iType(immOp[$unsigned($random(seed)) % 6], $random(seed) & 7,
					$random(seed) & 7, $random(seed));
				5: prog[i] = iType(15, 0, $random(seed) & 7, $random(seed));
				6: prog[i] = iType(43, 0, $random(seed) & 7, memOfs);
				7: prog[i] = iType(35, 0, $random(seed) & 7, memOfs);
				8: prog[i] = iType(4 + ($random(seed) & 1), $random(seed) & 7,
					$random(seed) & 7, $unsigned($random(seed)) % 4); // Forward only
				9: prog[i] = {6'd2 + 6'($random(seed) & 1), 26'($unsigned($random(seed)) % 64)};
				10: prog[i] = rType(31, 0, 0, 0, 8);
				default: prog[i] = {6'd63, 26'($random(seed))}; // Undefined opcode
			endcase
		end
	endtask

	// Stimulus on the falling edge
	initial begin
		instr = 32'd0;
		rstN = 1'b0;
		mPc = 32'd0;
		for (int r = 0; r < 32; r++) begin
			mReg[r] = 32'd0;
		end
		buildProgram();
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		repeat (RunCycles) @(negedge clk);
		#4;
		$display("Simulation passed");
		$finish;
	end

	always @(negedge clk) begin
		instr <= prog[instrAddr[7:2]]; // Fetch wraps modulo 64 words
	end

	// Compare process
	initial begin
		logic en;
		logic [4:0] wa;
		logic [31:0] wd;
		logic [31:0] npc;
		@(negedge clk);
		forever begin
			@(negedge clk);
			#2;
			if (!rstN) begin
				resetCycles++;
				if (resetCycles > 100) begin
					$display("Simulation failed");
					$fatal(1, "reset was never released");
				end
				checkEq("instrAddr", instrAddr, 32'd0);
				checkEq("wbEn", {31'd0, wbEn}, 32'd0);
			end else begin
				checkEq("instrAddr", instrAddr, mPc);
				stepModel(instr, en, wa, wd, npc);
				checkEq("wbEn", {31'd0, wbEn}, {31'd0, en});
				if (en) begin
					checkEq("wbAddr", {27'd0, wbAddr}, {27'd0, wa});
					checkEq("wbData", wbData, wd);
				end
			end
		end
	end

	initial begin
		#((RunCycles + 200) * 8);
		$display("Simulation failed");
		$fatal(1, "simulation timed out");
	end

endmodule

// ==== flist.f ====
+incdir+bench
src/isaPkg.sv
src/ctrlPkg.sv
src/coreIfs.sv
src/instrDecoder.sv
src/pcUnit.sv
src/regFile.sv
src/execUnit.sv
src/dataMemory.sv
src/mipsCore.sv
bench/tbMipsCore.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --top-module tbMipsCore -f flist.f -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log && exit 0 || exit 1

// ==== src/coreIfs.sv ====
`timescale 1ns/10ps

interface regReadIf;
	import isaPkg::*;

	regAddrT rsAddr;
	regAddrT rtAddr;
	wordT rsData;
	wordT rtData;

	modport source (output rsAddr, output rtAddr, input rsData, input rtData);
	modport target (input rsAddr, input rtAddr, output rsData, output rtData);
endinterface

interface dataMemIf;
	import isaPkg::*;

	wordT addr; // Byte address
	wordT wdata;
	logic wen;
	wordT rdata;

	modport source (output addr, output wdata, output wen, input rdata);
	modport target (input addr, input wdata, input wen, output rdata);
endinterface

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluLui
	} aluOpT;

	typedef enum logic {aSrcRs, aSrcRt} aSrcT; // Shifts take rt

	typedef enum logic [1:0] {bSrcRt, bSrcSext, bSrcZext, bSrcShamt} bSrcT;

	typedef enum logic [1:0] {dstRt, dstRd, dstLink} dstSelT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSelT;

	typedef struct packed {
		aluOpT aluOp;
		aSrcT aSrc;
		bSrcT bSrc;
		dstSelT dstSel;
		wbSelT wbSel;
		logic regWrite;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
		logic jumpReg;
	} ctrlT;

	// Writes nothing and steps the PC by 4
	localparam ctrlT ctrlNop = '{aluOp: aluAdd, aSrc: aSrcRs, bSrc: bSrcRt, dstSel: dstRt,
		wbSel: wbAlu, regWrite: 1'b0, memWrite: 1'b0, branchEq: 1'b0, branchNe: 1'b0,
		jump: 1'b0, jumpReg: 1'b0};

endpackage

// ==== src/dataMemory.sv ====
`timescale 1ns/10ps

module dataMemory #(
	parameter int DmemWords = 256
) (
	input logic clk,
	dataMemIf.target mem
);
	import isaPkg::*;

	localparam int IdxW = $clog2(DmemWords);

	wordT words [DmemWords];
	logic [IdxW-1:0] idx;

	assign idx = mem.addr[IdxW+1:2]; // Byte offset dropped and index wraps

	assign mem.rdata = words[idx];

	always_ff @(posedge clk) begin
		if (mem.wen) begin
			words[idx] <= mem.wdata;
		end
	end

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/10ps

module execUnit (
	input isaPkg::wordT instr,
	input ctrlPkg::ctrlT ctrl,
	input isaPkg::wordT pcPlus4,
	input logic rstN,
	regReadIf.source rd,
	dataMemIf.source mem,
	output logic zero,
	output isaPkg::wordT rsData,
	output logic wbEn,
	output isaPkg::regAddrT wbAddr,
	output isaPkg::wordT wbData
);
	import isaPkg::*;
	import ctrlPkg::*;

	regAddrT rdField;
	wordT immSext;
	wordT immZext;
	wordT shamtZext;
	wordT opA;
	wordT opB;
	wordT aluResult;

	assign rd.rsAddr = instr[25:21];
	assign rd.rtAddr = instr[20:16];
	assign rdField = instr[15:11];
	assign rsData = rd.rsData; // JR target

	assign immSext = {{(wordW-immW){instr[15]}}, instr[immW-1:0]};
	assign immZext = {{(wordW-immW){1'b0}}, instr[immW-1:0]};
	assign shamtZext = {{(wordW-shamtW){1'b0}}, instr[10:6]};

	assign opA = (ctrl.aSrc == aSrcRt) ? rd.rtData : rd.rsData;

	always_comb begin
		case (ctrl.bSrc)
			bSrcSext: opB = immSext;
			bSrcZext: opB = immZext;
			bSrcShamt: opB = shamtZext;
			default: opB = rd.rtData;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluNor: aluResult = ~(opA | opB);
			aluSlt: aluResult = {{(wordW-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluSltu: aluResult = {{(wordW-1){1'b0}}, opA < opB};
			aluSll: aluResult = opA << opB[shamtW-1:0];
			aluSrl: aluResult = opA >> opB[shamtW-1:0];
			aluLui: aluResult = {opB[immW-1:0], {(wordW-immW){1'b0}}};
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);

	assign mem.addr = aluResult;
	assign mem.wdata = rd.rtData;
	assign mem.wen = ctrl.memWrite & rstN;

	always_comb begin
		case (ctrl.dstSel)
			dstRd: wbAddr = rdField;
			dstLink: wbAddr = linkReg;
			default: wbAddr = rd.rtAddr;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			wbMem: wbData = mem.rdata;
			wbPc4: wbData = pcPlus4; // JAL link value
			default: wbData = aluResult;
		endcase
	end

	assign wbEn = ctrl.regWrite & rstN;

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
	input isaPkg::wordT instr,
	output ctrlPkg::ctrlT ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	opcodeT opcode;
	functT funct;
	logic shiftOk;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign shiftOk = (instr[25:21] == zeroReg); // Nonzero rs field is not a plain shift

	always_comb begin
		ctrl = ctrlNop;
		case (opcode)
			opSpecial: begin
				ctrl.dstSel = dstRd;
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd, fnAddu: ctrl.aluOp = aluAdd; // No overflow trap
					fnSub, fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnNor: ctrl.aluOp = aluNor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSltu: ctrl.aluOp = aluSltu;
					fnSll, fnSrl: begin
						ctrl.aluOp = (funct == fnSll) ? aluSll : aluSrl;
						ctrl.aSrc = aSrcRt;
						ctrl.bSrc = bSrcShamt;
						ctrl.regWrite = shiftOk;
					end
					fnJr: begin
						ctrl.regWrite = 1'b0;
						ctrl.jumpReg = 1'b1;
					end
					default: ctrl = ctrlNop;
				endcase
			end
			opAddi, opAddiu: begin
				ctrl.bSrc = bSrcSext;
				ctrl.regWrite = 1'b1;
			end
			opSlti: begin
				ctrl.aluOp = aluSlt;
				ctrl.bSrc = bSrcSext;
				ctrl.regWrite = 1'b1;
			end
			opAndi: begin
				ctrl.aluOp = aluAnd;
				ctrl.bSrc = bSrcZext;
				ctrl.regWrite = 1'b1;
			end
			opOri: begin
				ctrl.aluOp = aluOr;
				ctrl.bSrc = bSrcZext;
				ctrl.regWrite = 1'b1;
			end
			opXori: begin
				ctrl.aluOp = aluXor;
				ctrl.bSrc = bSrcZext;
				ctrl.regWrite = 1'b1;
			end
			opLui: begin
				ctrl.aluOp = aluLui;
				ctrl.bSrc = bSrcZext;
				ctrl.regWrite = 1'b1;
			end
			opLw: begin
				ctrl.bSrc = bSrcSext; // rs + offset
				ctrl.wbSel = wbMem;
				ctrl.regWrite = 1'b1;
			end
			opSw: begin
				ctrl.bSrc = bSrcSext;
				ctrl.memWrite = 1'b1;
			end
			opBeq: begin
				ctrl.aluOp = aluSub; // zero when rs == rt
				ctrl.branchEq = 1'b1;
			end
			opBne: begin
				ctrl.aluOp = aluSub;
				ctrl.branchNe = 1'b1;
			end
			opJ: ctrl.jump = 1'b1;
			opJal: begin
				ctrl.jump = 1'b1;
				ctrl.dstSel = dstLink;
				ctrl.wbSel = wbPc4;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl = ctrlNop;
		endcase
	end

endmodule

// ==== src/isaPkg.sv ====
package isaPkg;

	localparam int wordW = 32;
	localparam int regAddrW = 5;
	localparam int opW = 6;
	localparam int functW = 6;
	localparam int immW = 16;
	localparam int shamtW = 5;
	localparam int targetW = 26;

	typedef logic [wordW-1:0] wordT;
	typedef logic [regAddrW-1:0] regAddrT;
	typedef logic [opW-1:0] opcodeT;
	typedef logic [functW-1:0] functT;

	localparam opcodeT opSpecial = 6'd0; // R-type decoded on funct
	localparam opcodeT opJ = 6'd2;
	localparam opcodeT opJal = 6'd3;
	localparam opcodeT opBeq = 6'd4;
	localparam opcodeT opBne = 6'd5;
	localparam opcodeT opAddi = 6'd8;
	localparam opcodeT opAddiu = 6'd9;
	localparam opcodeT opSlti = 6'd10;
	localparam opcodeT opAndi = 6'd12;
	localparam opcodeT opOri = 6'd13;
	localparam opcodeT opXori = 6'd14;
	localparam opcodeT opLui = 6'd15;
	localparam opcodeT opLw = 6'd35;
	localparam opcodeT opSw = 6'd43;

	localparam functT fnSll = 6'd0;
	localparam functT fnSrl = 6'd2;
	localparam functT fnJr = 6'd8;
	localparam functT fnAdd = 6'd32;
	localparam functT fnAddu = 6'd33;
	localparam functT fnSub = 6'd34;
	localparam functT fnSubu = 6'd35;
	localparam functT fnAnd = 6'd36;
	localparam functT fnOr = 6'd37;
	localparam functT fnXor = 6'd38;
	localparam functT fnNor = 6'd39;
	localparam functT fnSlt = 6'd42;
	localparam functT fnSltu = 6'd43;

	localparam regAddrT zeroReg = 5'd0;
	localparam regAddrT linkReg = 5'd31; // JAL return address

endpackage

// ==== src/mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore #(
	parameter int DmemWords = 256
) (
	input logic clk,
	input logic rstN,
	input isaPkg::wordT instr,
	output isaPkg::wordT instrAddr,
	output logic wbEn,
	output isaPkg::regAddrT wbAddr,
	output isaPkg::wordT wbData
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlT ctrl;
	logic zero;
	wordT rsData;
	wordT pcPlus4;

	regReadIf rdBus ();
	dataMemIf memBus ();

	instrDecoder u_instrDecoder (
		.instr(instr),
		.ctrl(ctrl)
	);

	pcUnit u_pcUnit (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.ctrl(ctrl),
		.zero(zero),
		.rsData(rsData),
		.pc(instrAddr),
		.pcPlus4(pcPlus4)
	);

	regFile u_regFile (
		.clk(clk),
		.rstN(rstN),
		.rd(rdBus.target),
		.wen(wbEn),
		.waddr(wbAddr),
		.wdata(wbData)
	);

	execUnit u_execUnit (
		.instr(instr),
		.ctrl(ctrl),
		.pcPlus4(pcPlus4),
		.rstN(rstN),
		.rd(rdBus.source),
		.mem(memBus.source),
		.zero(zero),
		.rsData(rsData),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	dataMemory #(
		.DmemWords(DmemWords)
	) u_dataMemory (
		.clk(clk),
		.mem(memBus.target)
	);

endmodule

// ==== src/pcUnit.sv ====
`timescale 1ns/10ps

module pcUnit (
	input logic clk,
	input logic rstN,
	input isaPkg::wordT instr,
	input ctrlPkg::ctrlT ctrl,
	input logic zero,
	input isaPkg::wordT rsData,
	output isaPkg::wordT pc,
	output isaPkg::wordT pcPlus4
);
	import isaPkg::*;

	wordT branchOfs;
	wordT branchTarget;
	wordT jumpTarget;
	wordT pcNext;
	logic branchTaken;

	assign pcPlus4 = pc + wordT'(4);
	assign branchOfs = {{(wordW-immW-2){instr[15]}}, instr[immW-1:0], 2'b00};
	assign branchTarget = pcPlus4 + branchOfs;
	assign jumpTarget = {pcPlus4[31:28], instr[targetW-1:0], 2'b00}; // Same 256 MB region
	assign branchTaken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

	always_comb begin
		if (ctrl.jumpReg) begin
			pcNext = rsData;
		end else if (ctrl.jump) begin
			pcNext = jumpTarget;
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic rstN,
	regReadIf.target rd,
	input logic wen,
	input isaPkg::regAddrT waddr,
	input isaPkg::wordT wdata
);
	import isaPkg::*;

	wordT regs [2**regAddrW];

	always_ff @(posedge clk) begin
		if (rstN && wen && (waddr != zeroReg)) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is never written, so force it on read
	assign rd.rsData = (rd.rsAddr == zeroReg) ? '0 : regs[rd.rsAddr];
	assign rd.rtData = (rd.rtAddr == zeroReg) ? '0 : regs[rd.rtAddr];

endmodule
